// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sim.f
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
+incdir+verif
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_core.sv
verif/rv_core_chk.sv
verif/rv_core_tb.sv

// ==== src/rv_alu.sv ====
// integer alu and branch comparator
// computes the selected operation on a and b; the comparator works on
// the raw register operands and resolves the branch condition

`timescale 1ns/1ns

module rv_alu
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  xlen_t   a,
  input  xlen_t   b,
  input  alu_op_t op,
  input  funct3_t branch_funct3,
  input  xlen_t   rs1_data,
  input  xlen_t   rs2_data,
  output xlen_t   result,
  output logic    branch_taken
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $signed(a) >>> shamt;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

  // branch compare
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (branch_funct3)
      f3_beq:  branch_taken = eq;
      f3_bne:  branch_taken = !eq;
      f3_blt:  branch_taken = lt;
      f3_bge:  branch_taken = !lt;
      f3_bltu: branch_taken = ltu;
      f3_bgeu: branch_taken = !ltu;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== src/rv_core.sv ====
// single-cycle rv32i core
// holds the pc, picks the next pc and the writeback value, and ties
// decoder, register file, alu and load/store unit together

`timescale 1ns/1ns

module rv_core
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
#(
  parameter int    num_regs = 32,
  parameter xlen_t reset_pc = '0
) (
  input  logic     clk,
  input  logic     rst,
  output xlen_t    pc_to_imem,
  input  xlen_t    insn_from_imem,
  output xlen_t    addr_to_dmem,
  input  xlen_t    load_data_from_dmem,
  output xlen_t    store_data_to_dmem,
  output byte_en_t store_we_to_dmem,
  output logic     halt
);

  xlen_t        pc;
  xlen_t        pc_next;
  xlen_t        pc_plus4;
  xlen_t        pc_target;
  reg_addr_t    rs1;
  reg_addr_t    rs2;
  reg_addr_t    rd;
  xlen_t        imm;
  alu_op_t      alu_op;
  logic         alu_src_imm;
  logic         alu_src_pc;
  wb_sel_t      wb_sel;
  next_pc_sel_t next_pc_sel;
  logic         dec_reg_we;
  funct3_t      mem_funct3;
  logic         is_load;
  logic         is_store;
  xlen_t        rs1_data;
  xlen_t        rs2_data;
  xlen_t        alu_a;
  xlen_t        alu_b;
  xlen_t        alu_result;
  logic         branch_taken;
  xlen_t        load_result;
  byte_en_t     lsu_store_we;
  xlen_t        wb_data;
  logic         reg_we;

  assign pc_to_imem = pc;
  assign pc_plus4   = pc + 32'd4;
  assign pc_target  = pc + imm;
  assign alu_a      = alu_src_pc ? pc : rs1_data;
  assign alu_b      = alu_src_imm ? imm : rs2_data;

  // no architectural writes in reset or on ecall
  assign reg_we           = dec_reg_we && !rst && !halt;
  assign store_we_to_dmem = (rst || halt) ? '0 : lsu_store_we;

  always_comb begin
    case (wb_sel)
      wb_load:     wb_data = load_result;
      wb_pc_plus4: wb_data = pc_plus4;
      wb_imm:      wb_data = imm;
      default:     wb_data = alu_result;
    endcase
  end

  always_comb begin
    case (next_pc_sel)
      npc_branch: pc_next = branch_taken ? pc_target : pc_plus4;
      npc_jal:    pc_next = pc_target;
      npc_jalr:   pc_next = {alu_result[xlen-1:1], 1'b0};
      default:    pc_next = pc_plus4;
    endcase
    // halted core spins on the ecall
    if (halt) begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  rv_decoder u_decoder (
    .insn        (insn_from_imem),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .imm         (imm),
    .alu_op      (alu_op),
    .alu_src_imm (alu_src_imm),
    .alu_src_pc  (alu_src_pc),
    .wb_sel      (wb_sel),
    .next_pc_sel (next_pc_sel),
    .reg_we      (dec_reg_we),
    .mem_funct3  (mem_funct3),
    .is_load     (is_load),
    .is_store    (is_store),
    .halt        (halt)
  );

  rv_regfile #(
    .num_regs (num_regs)
  ) u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (rd),
    .rd_data  (wb_data),
    .we       (reg_we)
  );

  rv_alu u_alu (
    .a             (alu_a),
    .b             (alu_b),
    .op            (alu_op),
    .branch_funct3 (mem_funct3),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .result        (alu_result),
    .branch_taken  (branch_taken)
  );

  rv_lsu u_lsu (
    .base        (rs1_data),
    .imm         (imm),
    .funct3      (mem_funct3),
    .is_load     (is_load),
    .is_store    (is_store),
    .rs2_data    (rs2_data),
    .load_data   (load_data_from_dmem),
    .addr        (addr_to_dmem),
    .store_data  (store_data_to_dmem),
    .store_we    (lsu_store_we),
    .load_result (load_result)
  );

endmodule

// ==== src/rv_ctrl_pkg.sv ====
// core control encodings
// alu operation, immediate format, writeback source and next-pc source

package rv_ctrl_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  // immediate formats of the base isa
  typedef enum logic [2:0] {
    imm_type_i,
    imm_type_s,
    imm_type_b,
    imm_type_u,
    imm_type_j
  } imm_sel_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_pc_plus4,
    wb_imm
  } wb_sel_t;

  typedef enum logic [1:0] {
    npc_seq,
    npc_branch,
    npc_jal,
    npc_jalr
  } next_pc_sel_t;

endpackage

// ==== src/rv_decoder.sv ====
// rv32i instruction decoder
// splits the instruction word, builds the immediate and derives all
// datapath control; unknown encodings fall through as a plain pc + 4

`timescale 1ns/1ns

module rv_decoder
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  xlen_t        insn,
  output reg_addr_t    rs1,
  output reg_addr_t    rs2,
  output reg_addr_t    rd,
  output xlen_t        imm,
  output alu_op_t      alu_op,
  output logic         alu_src_imm,
  output logic         alu_src_pc,
  output wb_sel_t      wb_sel,
  output next_pc_sel_t next_pc_sel,
  output logic         reg_we,
  output funct3_t      mem_funct3,
  output logic         is_load,
  output logic         is_store,
  output logic         halt
);

  opcode_t  opcode;
  funct3_t  funct3;
  funct7_t  funct7;
  imm_sel_t imm_sel;
  logic     is_reg;
  logic     alt;
  logic     base;
  logic     alu_ok;

  assign opcode     = insn[6:0];
  assign rd         = insn[11:7];
  assign funct3     = insn[14:12];
  assign rs1        = insn[19:15];
  assign rs2        = insn[24:20];
  assign funct7     = insn[31:25];
  assign mem_funct3 = funct3;

  always_comb begin
    case (imm_sel)
      imm_type_s: imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      imm_type_b: imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      imm_type_u: imm = {insn[31:12], 12'b0};
      imm_type_j: imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      default:    imm = {{20{insn[31]}}, insn[31:20]};
    endcase
  end

  // alu function of op and op-imm from funct3 and funct7
  assign is_reg = (opcode == op_op);
  assign alt    = (funct7 == funct7_alt);
  assign base   = (funct7 == '0);

  always_comb begin
    alu_ok = 1'b1;
    case (funct3)
      f3_add: begin
        alu_op = (is_reg && alt) ? alu_sub : alu_add;
        alu_ok = !is_reg || base || alt;
      end
      f3_sll: begin
        alu_op = alu_sll;
        alu_ok = base;
      end
      f3_slt:  alu_op = alu_slt;
      f3_sltu: alu_op = alu_sltu;
      f3_xor:  alu_op = alu_xor;
      f3_sr: begin
        alu_op = alt ? alu_sra : alu_srl;
        alu_ok = base || alt;
      end
      f3_or:   alu_op = alu_or;
      default: alu_op = alu_and;
    endcase
    // remaining register-register forms need a zero funct7
    if (is_reg && funct3 != f3_add && funct3 != f3_sr && !base) begin
      alu_ok = 1'b0;
    end
    // auipc and jalr add, their funct3 bits carry no alu function
    if (opcode != op_op && opcode != op_op_imm) begin
      alu_op = alu_add;
    end
  end

  always_comb begin
    imm_sel     = imm_type_i;
    alu_src_imm = 1'b0;
    alu_src_pc  = 1'b0;
    wb_sel      = wb_alu;
    next_pc_sel = npc_seq;
    reg_we      = 1'b0;
    is_load     = 1'b0;
    is_store    = 1'b0;
    halt        = 1'b0;
    case (opcode)
      op_lui: begin
        imm_sel = imm_type_u;
        wb_sel  = wb_imm;
        reg_we  = 1'b1;
      end
      op_auipc: begin
        imm_sel     = imm_type_u;
        alu_src_pc  = 1'b1;
        alu_src_imm = 1'b1;
        reg_we      = 1'b1;
      end
      op_jal: begin
        imm_sel     = imm_type_j;
        wb_sel      = wb_pc_plus4;
        next_pc_sel = npc_jal;
        reg_we      = 1'b1;
      end
      op_jalr: begin
        if (funct3 == '0) begin
          alu_src_imm = 1'b1;
          wb_sel      = wb_pc_plus4;
          next_pc_sel = npc_jalr;
          reg_we      = 1'b1;
        end
      end
      op_branch: begin
        imm_sel = imm_type_b;
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          next_pc_sel = npc_branch;
        end
      end
      op_load: begin
        if (funct3 inside {f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu}) begin
          is_load = 1'b1;
          wb_sel  = wb_load;
          reg_we  = 1'b1;
        end
      end
      op_store: begin
        imm_sel  = imm_type_s;
        is_store = funct3 inside {f3_sb, f3_sh, f3_sw};
      end
      op_op_imm, op_op: begin
        alu_src_imm = !is_reg;
        reg_we      = alu_ok;
      end
      // fence orders nothing in a single-cycle core
      op_misc_mem: ;
      op_system: halt = (insn[31:7] == '0);
      default: ;
    endcase
  end

endmodule

// ==== src/rv_isa_pkg.sv ====
// rv32i instruction set definitions
// field widths, major opcodes, funct3 and funct7 codes of the base encoding

package rv_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int opcode_w   = 7;
  localparam int funct3_w   = 3;
  localparam int funct7_w   = 7;

  typedef logic [xlen-1:0]       xlen_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [opcode_w-1:0]   opcode_t;
  typedef logic [funct3_w-1:0]   funct3_t;
  typedef logic [funct7_w-1:0]   funct7_t;
  typedef logic [xlen/8-1:0]     byte_en_t;

  // major opcodes
  localparam opcode_t op_load     = 7'b00_000_11;
  localparam opcode_t op_store    = 7'b01_000_11;
  localparam opcode_t op_branch   = 7'b11_000_11;
  localparam opcode_t op_jalr     = 7'b11_001_11;
  localparam opcode_t op_misc_mem = 7'b00_011_11;
  localparam opcode_t op_jal      = 7'b11_011_11;
  localparam opcode_t op_op_imm   = 7'b00_100_11;
  localparam opcode_t op_op       = 7'b01_100_11;
  localparam opcode_t op_system   = 7'b11_100_11;
  localparam opcode_t op_auipc    = 7'b00_101_11;
  localparam opcode_t op_lui      = 7'b01_101_11;

  // branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // load and store widths
  localparam funct3_t f3_lb  = 3'b000;
  localparam funct3_t f3_lh  = 3'b001;
  localparam funct3_t f3_lw  = 3'b010;
  localparam funct3_t f3_lbu = 3'b100;
  localparam funct3_t f3_lhu = 3'b101;
  localparam funct3_t f3_sb  = 3'b000;
  localparam funct3_t f3_sh  = 3'b001;
  localparam funct3_t f3_sw  = 3'b010;

  // alu functions, shared by op and op-imm
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // selects sub and sra
  localparam funct7_t funct7_alt = 7'b0100000;

endpackage

// ==== src/rv_lsu.sv ====
// load/store unit
// forms the word-aligned data address, steers store data onto byte lanes
// with a matching write mask, and extracts and extends load data

`timescale 1ns/1ns

module rv_lsu
  import rv_isa_pkg::*;
(
  input  xlen_t    base,
  input  xlen_t    imm,
  input  funct3_t  funct3,
  input  logic     is_load,
  input  logic     is_store,
  input  xlen_t    rs2_data,
  input  xlen_t    load_data,
  output xlen_t    addr,
  output xlen_t    store_data,
  output byte_en_t store_we,
  output xlen_t    load_result
);

  xlen_t       eff_addr;
  logic [1:0]  offset;
  logic [7:0]  load_byte;
  logic [15:0] load_half;

  assign eff_addr = base + imm;
  assign offset   = eff_addr[1:0];
  assign addr     = (is_load || is_store) ? {eff_addr[xlen-1:2], 2'b00} : '0;

  // data replicated on every lane, the mask picks the live one
  always_comb begin
    store_data = '0;
    store_we   = '0;
    if (is_store) begin
      case (funct3)
        f3_sb: begin
          store_data = {4{rs2_data[7:0]}};
          store_we   = byte_en_t'(4'b0001 << offset);
        end
        f3_sh: begin
          store_data = {2{rs2_data[15:0]}};
          store_we   = offset[1] ? 4'b1100 : 4'b0011;
        end
        f3_sw: begin
          store_data = rs2_data;
          store_we   = 4'b1111;
        end
        default: ;
      endcase
    end
  end

  // halfword lane from bit 1 only
  assign load_byte = load_data[{offset, 3'b000} +: 8];
  assign load_half = offset[1] ? load_data[31:16] : load_data[15:0];

  always_comb begin
    case (funct3)
      f3_lb:   load_result = {{24{load_byte[7]}}, load_byte};
      f3_lh:   load_result = {{16{load_half[15]}}, load_half};
      f3_lbu:  load_result = {24'b0, load_byte};
      f3_lhu:  load_result = {16'b0, load_half};
      default: load_result = load_data;
    endcase
  end

endmodule

// ==== src/rv_regfile.sv ====
// integer register file
// two asynchronous read ports, one synchronous write port, x0 reads zero

`timescale 1ns/1ns

module rv_regfile
  import rv_isa_pkg::*;
#(
  parameter int num_regs = 32
) (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output xlen_t     rs1_data,
  output xlen_t     rs2_data,
  input  reg_addr_t rd,
  input  xlen_t     rd_data,
  input  logic      we
);

  localparam int idx_w = $clog2(num_regs);

  xlen_t regs [num_regs];

  // indices beyond the implemented set behave like x0
  assign rs1_data = (rs1 != '0 && rs1 < num_regs) ? regs[rs1[idx_w-1:0]] : '0;
  assign rs2_data = (rs2 != '0 && rs2 < num_regs) ? regs[rs2[idx_w-1:0]] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0 && rd < num_regs) begin
      regs[rd[idx_w-1:0]] <= rd_data;
    end
  end

endmodule

// ==== verif/rv_core_chk.sv ====
// memory port checks for the rv32i core
// bound into the core; bus alignment, write mask shape and halt behavior

`timescale 1ns/1ns

module rv_core_chk
  import rv_isa_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input xlen_t    pc_to_imem,
  input xlen_t    addr_to_dmem,
  input byte_en_t store_we_to_dmem,
  input logic     halt
);

  dmem_aligned: assert property (
    @(posedge clk) disable iff (rst) addr_to_dmem[1:0] == 2'b00
  ) else $error("data address %08h not word aligned", addr_to_dmem);

  // byte, halfword or word lanes only
  we_shape: assert property (
    @(posedge clk) store_we_to_dmem inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf}
  ) else $error("illegal store enable mask %b", store_we_to_dmem);

  pc_aligned: assert property (
    @(posedge clk) disable iff (rst) pc_to_imem[1:0] == 2'b00
  ) else $error("pc %08h not word aligned", pc_to_imem);

  halt_no_store: assert property (
    @(posedge clk) disable iff (rst) halt |-> store_we_to_dmem == '0
  ) else $error("store enabled while halted");

  halt_pc_hold: assert property (
    @(posedge clk) disable iff (rst) halt |=> $stable(pc_to_imem)
  ) else $error("pc moved after halt");

endmodule

// ==== verif/rv_iss.svh ====
// rv32i reference model and random program generator
// shares the program memory with the testbench, keeps its own registers,
// pc and copy of the data region at 0x1000

`ifndef RV_ISS_SVH
`define RV_ISS_SVH

localparam int prog_words = 512;
localparam int data_words = 64;

localparam int kind_alu   = 0;
localparam int kind_load  = 1;
localparam int kind_store = 2;
localparam int kind_ctrl  = 3;
localparam int kind_upper = 4;
localparam int kind_mix   = 5;

// x14 holds the data base, x15 the jalr targets
localparam logic [4:0]  data_reg  = 5'd14;
localparam logic [4:0]  jump_reg  = 5'd15;
localparam logic [31:0] nop_insn  = 32'h0000_0013;
localparam logic [31:0] ecall_insn = 32'h0000_0073;

logic [31:0] imem [prog_words];
logic [31:0] iss_regs [32];
logic [31:0] iss_mem [data_words];
logic [31:0] iss_pc;
int          prog_len;

// predicted effect of the instruction at iss_pc
logic [31:0] e_npc;
logic [31:0] e_addr;
logic [31:0] e_data;
logic [3:0]  e_we;
logic [4:0]  e_rd;
logic [31:0] e_rdval;
logic        e_halt;

function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
  logic [31:0] up;
  up = v << (32 - bits);
  return $signed(up) >>> (32 - bits);
endfunction

function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return {31'b0, $signed(a) < $signed(b)};
    3'd3:    return {31'b0, a < b};
    3'd4:    return a ^ b;
    3'd5: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
  case (f3)
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return $signed(a) < $signed(b);
    3'd5:    return $signed(a) >= $signed(b);
    3'd6:    return a < b;
    3'd7:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

task automatic iss_eval();
  logic [31:0] insn;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] ea;
  logic [31:0] ld;
  logic [2:0]  f3;
  insn    = imem[iss_pc[10:2]];
  f3      = insn[14:12];
  a       = iss_regs[insn[19:15]];
  b       = iss_regs[insn[24:20]];
  e_npc   = iss_pc + 32'd4;
  e_rd    = 5'd0;
  e_rdval = '0;
  e_we    = '0;
  e_addr  = '0;
  e_data  = '0;
  e_halt  = (insn == ecall_insn);
  case (insn[6:0])
    op_lui: begin
      e_rd    = insn[11:7];
      e_rdval = {insn[31:12], 12'b0};
    end
    op_auipc: begin
      e_rd    = insn[11:7];
      e_rdval = iss_pc + {insn[31:12], 12'b0};
    end
    op_jal: begin
      e_rd    = insn[11:7];
      e_rdval = iss_pc + 32'd4;
      e_npc   = iss_pc + sext(32'({insn[31], insn[19:12], insn[20], insn[30:21], 1'b0}), 21);
    end
    op_jalr: begin
      e_rd    = insn[11:7];
      e_rdval = iss_pc + 32'd4;
      e_npc   = (a + sext(32'(insn[31:20]), 12)) & ~32'd1;
    end
    op_branch: begin
      if (branch_cond(f3, a, b)) begin
        e_npc = iss_pc + sext(32'({insn[31], insn[7], insn[30:25], insn[11:8], 1'b0}), 13);
      end
    end
    op_load: begin
      ea      = a + sext(32'(insn[31:20]), 12);
      e_addr  = {ea[31:2], 2'b00};
      ld      = iss_mem[ea[7:2]] >> {ea[1:0], 3'b000};
      e_rd    = insn[11:7];
      case (f3)
        3'd0:    e_rdval = sext(32'(ld[7:0]), 8);
        3'd1:    e_rdval = sext(32'(ld[15:0]), 16);
        3'd4:    e_rdval = 32'(ld[7:0]);
        3'd5:    e_rdval = 32'(ld[15:0]);
        default: e_rdval = ld;
      endcase
    end
    op_store: begin
      ea     = a + sext(32'({insn[31:25], insn[11:7]}), 12);
      e_addr = {ea[31:2], 2'b00};
      e_data = b << {ea[1:0], 3'b000};
      case (f3)
        3'd0:    e_we = 4'b0001 << ea[1:0];
        3'd1:    e_we = 4'b0011 << ea[1:0];
        default: e_we = 4'b1111;
      endcase
    end
    op_op_imm: begin
      e_rd    = insn[11:7];
      e_rdval = alu_calc(f3, insn[30] && f3 == 3'd5, a, sext(32'(insn[31:20]), 12));
    end
    op_op: begin
      e_rd    = insn[11:7];
      e_rdval = alu_calc(f3, insn[30], a, b);
    end
    op_system: begin
      if (e_halt) begin
        e_npc = iss_pc;
      end
    end
    default: ;
  endcase
endtask

task automatic iss_step();
  if (e_rd != 5'd0) begin
    iss_regs[e_rd] = e_rdval;
  end
  for (int i = 0; i < 4; i++) begin
    if (e_we[i]) begin
      iss_mem[e_addr[7:2]][8*i +: 8] = e_data[8*i +: 8];
    end
  end
  iss_pc = e_npc;
endtask

// encoders
function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, op_op};
endfunction

function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                      input logic [19:0] imm);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

task automatic emit(input logic [31:0] insn);
  imem[prog_len] = insn;
  prog_len++;
endtask

function automatic logic [31:0] rand_alu(input logic [4:0] rd);
  logic [2:0] f3;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [6:0] f7;
  f3  = 3'($urandom_range(0, 7));
  rs1 = 5'($urandom_range(0, 13));
  rs2 = 5'($urandom_range(0, 13));
  // alternate funct7 only for sub and sra
  f7  = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
  if ($urandom_range(0, 1) == 1) begin
    return enc_r(f7, f3, rd, rs1, rs2);
  end
  if (f3 == 3'd1 || f3 == 3'd5) begin
    return enc_i(op_op_imm, f3, rd, rs1, {(f3 == 3'd5) ? f7 : 7'h00, rs2});
  end
  return enc_i(op_op_imm, f3, rd, rs1, 12'($urandom));
endfunction

// naturally aligned offset inside the data region
function automatic logic [11:0] rand_offset(input logic [1:0] size);
  logic [11:0] off;
  off = 12'($urandom_range(0, 255));
  return off & ~((12'd1 << size) - 12'd1);
endfunction

task automatic gen_program(input int kind);
  int          sel;
  int          k;
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic [31:0] tgt;
  for (int i = 0; i < prog_words; i++) begin
    imem[i] = enc_i(op_op_imm, f3_add, 5'd0, 5'd0, 12'(i));
  end
  prog_len = 0;
  // slot 0 executes on the edge that leaves reset
  emit(nop_insn);
  emit(enc_u(op_lui, data_reg, 20'h1));
  for (int r = 1; r < 14; r++) begin
    emit(enc_u(op_lui, 5'(r), 20'($urandom)));
    emit(enc_i(op_op_imm, f3_add, 5'(r), 5'(r), 12'($urandom)));
  end
  for (int n = 0; n < 32; n++) begin
    sel = (kind == kind_mix) ? $urandom_range(0, 4) : kind;
    rd  = 5'($urandom_range(1, 13));
    case (sel)
      kind_alu: emit(rand_alu(rd));
      kind_load: begin
        f3 = 3'($urandom_range(0, 4));
        f3 = (f3 >= 3'd3) ? f3 + 3'd1 : f3;
        emit(enc_i(op_load, f3, rd, data_reg, rand_offset(f3[1:0])));
      end
      kind_store: begin
        f3 = 3'($urandom_range(0, 2));
        emit(enc_s(f3, data_reg, 5'($urandom_range(0, 13)), rand_offset(f3[1:0])));
      end
      kind_ctrl: begin
        k = $urandom_range(1, 3);
        case ($urandom_range(0, 2))
          0: begin
            f3 = 3'($urandom_range(0, 5));
            f3 = (f3 >= 3'd2) ? f3 + 3'd2 : f3;
            emit(enc_b(f3, 5'($urandom_range(0, 13)), 5'($urandom_range(0, 13)),
                       13'(4 * (k + 1))));
          end
          1: emit(enc_j(rd, 21'(4 * (k + 1))));
          default: begin
            tgt = 32'(4 * (prog_len + 3 + k));
            emit(enc_u(op_lui, jump_reg, 20'((tgt + 32'h800) >> 12)));
            emit(enc_i(op_op_imm, f3_add, jump_reg, jump_reg, tgt[11:0]));
            // an odd offset exercises the cleared target bit
            emit(enc_i(op_jalr, 3'd0, rd, jump_reg, 12'($urandom_range(0, 1))));
          end
        endcase
        for (int f = 0; f < k; f++) begin
          emit(rand_alu(rd));
        end
      end
      default: begin
        rd = ($urandom_range(0, 3) == 0) ? 5'd0 : rd;
        case ($urandom_range(0, 2))
          0: emit(enc_u(op_lui, rd, 20'($urandom)));
          1: emit(enc_u(op_auipc, rd, 20'($urandom)));
          default: emit(enc_i(op_op_imm, f3_add, rd, 5'($urandom_range(0, 13)),
                              12'($urandom)));
        endcase
      end
    endcase
    // results become visible through a word store
    if (sel != kind_store) begin
      emit(enc_s(f3_sw, data_reg, rd, 12'(4 * $urandom_range(0, 63))));
    end
  end
  emit(ecall_insn);
endtask

`endif

// ==== verif/rv_core_tb.sv ====
// testbench for the single-cycle rv32i core
// runs random programs against a reference model and compares fetch,
// data bus and halt outputs every cycle

`timescale 1ns/1ns

module rv_core_tb
  import rv_isa_pkg::*;
();

  localparam int    halt_timeout = 2000;
  localparam xlen_t reset_addr   = 32'h0;

  logic     clk;
  logic     rst;
  xlen_t    pc_to_imem;
  xlen_t    insn_from_imem;
  xlen_t    addr_to_dmem;
  xlen_t    load_data_from_dmem;
  xlen_t    store_data_to_dmem;
  byte_en_t store_we_to_dmem;
  logic     halt;

  int err_count;
  int cycle_count;
  int pass_tests;
  int fail_tests;

  `include "rv_iss.svh"

  logic [31:0] dmem [data_words];

  rv_core #(
    .num_regs (32),
    .reset_pc (reset_addr)
  ) DUT (
    .clk                 (clk),
    .rst                 (rst),
    .pc_to_imem          (pc_to_imem),
    .insn_from_imem      (insn_from_imem),
    .addr_to_dmem        (addr_to_dmem),
    .load_data_from_dmem (load_data_from_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .store_we_to_dmem    (store_we_to_dmem),
    .halt                (halt)
  );

  bind rv_core rv_core_chk u_chk (
    .clk              (clk),
    .rst              (rst),
    .pc_to_imem       (pc_to_imem),
    .addr_to_dmem     (addr_to_dmem),
    .store_we_to_dmem (store_we_to_dmem),
    .halt             (halt)
  );

  always #50 clk = ~clk;

  // combinational memory reads
  assign insn_from_imem      = imem[pc_to_imem[10:2]];
  assign load_data_from_dmem = dmem[addr_to_dmem[7:2]];

  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (store_we_to_dmem[i]) begin
        dmem[addr_to_dmem[7:2]][8*i +: 8] = store_data_to_dmem[8*i +: 8];
      end
    end
  end

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    err_count++;
    $display("error %s: %s expected %08h actual %08h (iss pc %08h)",
             test, what, expected, actual, iss_pc);
  endtask

  task automatic compare_cycle(input string test);
    logic [31:0] mask;
    mask = {{8{e_we[3]}}, {8{e_we[2]}}, {8{e_we[1]}}, {8{e_we[0]}}};
    cycle_count++;
    if (pc_to_imem !== iss_pc) begin
      report_mismatch(test, "pc", iss_pc, pc_to_imem);
    end
    if (halt !== e_halt) begin
      report_mismatch(test, "halt", 32'(e_halt), 32'(halt));
    end
    if (store_we_to_dmem !== e_we) begin
      report_mismatch(test, "store enables", 32'(e_we), 32'(store_we_to_dmem));
    end
    if (addr_to_dmem !== e_addr) begin
      report_mismatch(test, "data address", e_addr, addr_to_dmem);
    end
    if ((store_data_to_dmem & mask) !== (e_data & mask)) begin
      report_mismatch(test, "store data", e_data & mask, store_data_to_dmem & mask);
    end
  endtask

  task automatic run_test(input string test, input int kind);
    int          cycles;
    int          errs_at_start;
    logic        halted;
    errs_at_start = err_count;
    rst = 1'b1;
    gen_program(kind);
    for (int i = 0; i < data_words; i++) begin
      dmem[i]    = $urandom;
      iss_mem[i] = dmem[i];
    end
    for (int r = 0; r < 32; r++) begin
      iss_regs[r] = '0;
    end
    iss_pc = reset_addr + 32'd4;
    repeat (10) @(negedge clk);
    rst    = 1'b0;
    halted = 1'b0;
    cycles = 0;
    while (!halted && cycles < halt_timeout) begin
      @(negedge clk);
      cycles++;
      iss_eval();
      compare_cycle(test);
      if (e_halt || halt) begin
        halted = 1'b1;
      end else begin
        iss_step();
      end
    end
    if (!halted) begin
      err_count++;
      $display("test %s: core never halted within %0d cycles", test, halt_timeout);
    end else if (halt && e_halt) begin
      // ecall must hold the pc and keep stores off
      repeat (5) begin
        @(negedge clk);
        cycle_count++;
        if (pc_to_imem !== iss_pc) begin
          report_mismatch(test, "pc after halt", iss_pc, pc_to_imem);
        end
        if (store_we_to_dmem !== '0) begin
          report_mismatch(test, "store enables after halt", '0, 32'(store_we_to_dmem));
        end
      end
    end
    if (err_count == errs_at_start) begin
      pass_tests++;
      $display("test %s passed in %0d cycles", test, cycles);
    end else begin
      fail_tests++;
      $display("test %s failed with %0d errors", test, err_count - errs_at_start);
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    err_count   = 0;
    cycle_count = 0;
    pass_tests  = 0;
    fail_tests  = 0;
    void'($urandom(45));
    run_test("alu", kind_alu);
    run_test("loads", kind_load);
    run_test("stores", kind_store);
    run_test("control flow", kind_ctrl);
    run_test("upper immediates", kind_upper);
    run_test("halt", kind_mix);
    $display("tests passed %0d, failed %0d, cycles checked %0d, errors %0d",
             pass_tests, fail_tests, cycle_count, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
